//--- snooper_macros.svh
`ifndef SNOOPER_MACROS_SVH
`define SNOOPER_MACROS_SVH

// data and address widths
`define DATA_WIDTH        32
`define ADDRESS_WIDTH     32   // word address, no byte bits

// cache geometry
`define CACHE_OFFSET_BITS 2    // word offset inside a line
`define CACHE_WORDS       4
`define LINE_WIDTH        (`DATA_WIDTH * `CACHE_WORDS)
`define INDEX_BITS        8
`define TAG_BITS          22   // address bits above index and offset
`define WAY_BITS          2    // four ways

// metadata and messages
`define COHERENCE_BITS    2
`define STATUS_BITS       2
`define MSG_BITS          4

`endif

//--- snooper_pkg.sv
`include "snooper_macros.svh"

package snooper_pkg;

    typedef logic [`ADDRESS_WIDTH-1:0]                  addr_t;
    typedef logic [`DATA_WIDTH-1:0]                     word_t;
    typedef logic [`LINE_WIDTH-1:0]                     line_t;   // word 0 in the low bits
    typedef logic [`INDEX_BITS-1:0]                     index_t;
    typedef logic [`TAG_BITS-1:0]                       tag_t;
    typedef logic [`WAY_BITS-1:0]                       way_t;
    typedef logic [`STATUS_BITS-1:0]                    status_t; // {valid, dirty}
    typedef logic [`STATUS_BITS+`COHERENCE_BITS-1:0]    meta_t;   // {status, coherence}

    typedef enum logic [`COHERENCE_BITS-1:0] {
        INVALID   = 0,
        SHARED    = 1,
        EXCLUSIVE = 2,
        MODIFIED  = 3
    } coh_state_t;

    // shared bus and L1 interface messages
    typedef enum logic [`MSG_BITS-1:0] {
        NO_REQ    = 0,
        R_REQ     = 1,
        RFO_BCAST = 2,
        WS_BCAST  = 3,
        FLUSH_S   = 4,
        C_WB      = 5,
        C_FLUSH   = 6,
        EN_ACCESS = 7,
        MEM_RESP  = 8
    } bus_msg_t;

    typedef enum logic [2:0] {
        IDLE, START, READ_LINE, ACTION, WRITE_LINE, WAIT_FOR_RESP
    } snoop_state_t;

endpackage

//--- snoop_req_if.sv
`timescale 1ns/10ps

// one pending snoop request, held by capture until the controller is done
interface snoop_req_if import snooper_pkg::*; ();

    logic     valid;    // request pending
    bus_msg_t msg;
    addr_t    address;
    logic     done;     // controller finished, single cycle

    modport capture (
        output valid, msg, address,
        input  done
    );

    modport controller (
        input  valid, msg, address,
        output done
    );

endinterface

//--- snoop_request_capture.sv
`timescale 1ns/10ps

module snoop_request_capture import snooper_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  bus_msg_t     bus_msg,
    input  addr_t        bus_address,
    input  logic         bus_master,
    input  logic         req_ready,
    snoop_req_if.capture req
);

    logic snoop_type;   // message this cache has to answer
    logic qualify;

    always_comb begin
        case (bus_msg)
            R_REQ, RFO_BCAST, WS_BCAST, FLUSH_S: snoop_type = 1'b1;
            default:                             snoop_type = 1'b0;
        endcase
    end

    // only requests from other masters, and not while the bus is completing one
    assign qualify = snoop_type & ~bus_master & ~req_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else if (req.valid) begin
            if (req.done) begin
                req.valid <= 1'b0;  // free again on the next edge
            end
        end else if (qualify) begin
            req.valid <= 1'b1;
        end
    end

    // message and address stay frozen while a request is pending
    always_ff @(posedge clock) begin
        if (!req.valid && qualify) begin
            req.msg     <= bus_msg;
            req.address <= bus_address;
        end
    end

endmodule

//--- snoop_line_controller.sv
`timescale 1ns/10ps
`include "snooper_macros.svh"

module snoop_line_controller import snooper_pkg::*; (
    snoop_req_if.controller req,
    input  logic     clock,
    input  logic     reset,

    // cache lookup port
    input  line_t    data_in,
    input  way_t     matched_way,
    input  status_t  status_bits,
    input  logic     hit,
    output logic     read,
    output logic     write,
    output logic     invalidate,
    output index_t   index,
    output tag_t     tag,
    output meta_t    meta_data,
    output line_t    data_out,
    output way_t     way_select,

    // L1 bus interface
    input  bus_msg_t intf_msg,
    input  logic     req_ready,
    output bus_msg_t snoop_msg,
    output addr_t    snoop_address,
    output line_t    snoop_data
);

    snoop_state_t state;

    addr_t line_address;      // request address with the word offset cleared
    logic  dirty;
    logic  clean_share;       // clean R_REQ hit, downgrade to shared
    logic  writeback;         // dirty hit that has to go back to memory
    logic  writeback_pending;
    logic  release_req;

    assign line_address = {req.address[`ADDRESS_WIDTH-1:`CACHE_OFFSET_BITS],
                           {`CACHE_OFFSET_BITS{1'b0}}};

    assign dirty = status_bits[0];

    // lookup results are valid while in READ_LINE
    assign clean_share = (req.msg == R_REQ) && hit && !dirty;
    assign writeback   = hit && dirty && ((req.msg == R_REQ) || (req.msg == FLUSH_S));

    assign writeback_pending = (snoop_msg == C_WB) || (snoop_msg == C_FLUSH);

    // bus has taken EN_ACCESS, the request is finished
    assign release_req = (state == WAIT_FOR_RESP) && !writeback_pending && req_ready;
    assign req.done    = release_req;

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= IDLE;
            read          <= 1'b0;
            write         <= 1'b0;
            invalidate    <= 1'b0;
            snoop_msg     <= NO_REQ;
            snoop_address <= '0;
            snoop_data    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req.valid) begin
                        read  <= 1'b1;  // held until the outcome has been issued
                        state <= START;
                    end
                end

                START: begin
                    state <= READ_LINE;
                end

                READ_LINE: begin
                    if (clean_share) begin
                        write <= 1'b1;
                        state <= WRITE_LINE;
                    end else begin
                        invalidate <= hit;  // every other hit loses the line
                        state      <= ACTION;
                        if (writeback) begin
                            snoop_msg     <= (req.msg == FLUSH_S) ? C_FLUSH : C_WB;
                            snoop_address <= line_address;
                            snoop_data    <= data_in;
                        end else begin
                            snoop_msg     <= EN_ACCESS;
                            snoop_address <= req.address;
                            snoop_data    <= '0;
                        end
                    end
                end

                ACTION: begin
                    read       <= 1'b0;
                    invalidate <= 1'b0;
                    state      <= WAIT_FOR_RESP;
                end

                WRITE_LINE: begin
                    read          <= 1'b0;
                    write         <= 1'b0;
                    snoop_msg     <= EN_ACCESS;
                    snoop_address <= req.address;
                    snoop_data    <= '0;
                    state         <= WAIT_FOR_RESP;
                end

                WAIT_FOR_RESP: begin
                    if (writeback_pending) begin
                        // memory has the line, let the requester go ahead
                        if (intf_msg == MEM_RESP) begin
                            snoop_msg     <= EN_ACCESS;
                            snoop_address <= req.address;
                            snoop_data    <= '0;
                        end
                    end else if (release_req) begin
                        snoop_msg     <= NO_REQ;
                        snoop_address <= '0;
                        snoop_data    <= '0;
                        state         <= IDLE;
                    end
                end

                default: begin
                    read       <= 1'b0;
                    write      <= 1'b0;
                    invalidate <= 1'b0;
                    snoop_msg  <= NO_REQ;
                    state      <= IDLE;
                end
            endcase
        end
    end

    // lookup address and write-back payload toward the cache
    always_ff @(posedge clock) begin
        if (state == IDLE && req.valid) begin
            index <= req.address[`CACHE_OFFSET_BITS +: `INDEX_BITS];
            tag   <= req.address[`ADDRESS_WIDTH-1 -: `TAG_BITS];
        end
        if (state == READ_LINE) begin
            way_select <= matched_way;
            if (clean_share) begin
                meta_data <= {status_t'(2'b10), SHARED};  // valid, clean
                data_out  <= data_in;                     // line itself is unchanged
            end
        end
    end

endmodule

//--- snooper.sv
`timescale 1ns/10ps

module snooper import snooper_pkg::*; (
    input  logic     clock,
    input  logic     reset,

    // cache lookup port
    input  line_t    data_in,
    input  way_t     matched_way,
    input  status_t  status_bits,
    input  logic     hit,
    output logic     read,
    output logic     write,
    output logic     invalidate,
    output index_t   index,
    output tag_t     tag,
    output meta_t    meta_data,
    output line_t    data_out,
    output way_t     way_select,

    // L1 bus interface
    input  bus_msg_t intf_msg,
    output bus_msg_t snoop_msg,
    output addr_t    snoop_address,
    output line_t    snoop_data,

    // shared bus
    input  bus_msg_t bus_msg,
    input  addr_t    bus_address,
    input  logic     req_ready,
    input  logic     bus_master
);

    snoop_req_if req_if ();

    snoop_request_capture capture_i (
        .clock       (clock),
        .reset       (reset),
        .bus_msg     (bus_msg),
        .bus_address (bus_address),
        .bus_master  (bus_master),
        .req_ready   (req_ready),
        .req         (req_if.capture)
    );

    snoop_line_controller controller_i (
        .req           (req_if.controller),
        .clock         (clock),
        .reset         (reset),
        .data_in       (data_in),
        .matched_way   (matched_way),
        .status_bits   (status_bits),
        .hit           (hit),
        .read          (read),
        .write         (write),
        .invalidate    (invalidate),
        .index         (index),
        .tag           (tag),
        .meta_data     (meta_data),
        .data_out      (data_out),
        .way_select    (way_select),
        .intf_msg      (intf_msg),
        .req_ready     (req_ready),
        .snoop_msg     (snoop_msg),
        .snoop_address (snoop_address),
        .snoop_data    (snoop_data)
    );

endmodule

//--- snooper_asserts.sv
`timescale 1ns/10ps

module snooper_asserts import snooper_pkg::*; (
    input logic         clock, reset, hit, read, write, invalidate, req_ready, bus_master,
    input line_t        data_in, data_out, snoop_data,
    input way_t         matched_way, way_select,
    input status_t      status_bits,
    input index_t       index,
    input tag_t         tag,
    input meta_t        meta_data,
    input bus_msg_t     intf_msg, snoop_msg, bus_msg,
    input addr_t        snoop_address, bus_address,
    input snoop_state_t state
);

    int       error_count = 0;
    logic     busy;          // a snoop is being served
    bus_msg_t req_msg;       // request as it was seen on the bus
    addr_t    req_address;
    logic     qualify;
    logic     lookup;

    assign qualify = (bus_msg inside {R_REQ, RFO_BCAST, WS_BCAST, FLUSH_S})
                     && !bus_master && !req_ready;
    assign lookup  = (state == READ_LINE);  // cache answer is taken here

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (!busy && qualify) begin
            busy        <= 1'b1;
            req_msg     <= bus_msg;
            req_address <= bus_address;
        end else if (state == WAIT_FOR_RESP && snoop_msg == EN_ACCESS && req_ready) begin
            busy <= 1'b0;
        end
    end

    task automatic flag_failure(input string what);
        error_count++;
        $error("Fail %0t: %s", $time, what);
    endtask

    idle_quiet: assert property (@(posedge clock) disable iff (reset)
        !busy |-> !read && !write && !invalidate && snoop_msg == NO_REQ)
        else flag_failure("cache port or snoop_msg active without a request");

    read_start: assert property (@(posedge clock) disable iff (reset)
        !busy && qualify |=> ##1 read && index == req_address[9:2]
                                     && tag == req_address[31:10])
        else flag_failure("read, index or tag wrong two edges after the request");

    read_length: assert property (@(posedge clock) disable iff (reset)
        $rose(read) |-> read [*3] ##1 !read)
        else flag_failure("read not high for exactly three cycles");

    // clean R_REQ hit drops the line to shared
    clean_share: assert property (@(posedge clock) disable iff (reset)
        lookup && req_msg == R_REQ && hit && !status_bits[0]
        |=> write && !invalidate && meta_data == {2'b10, SHARED}
            && data_out == $past(data_in) && way_select == $past(matched_way)
        ##1 !write && snoop_msg == EN_ACCESS && snoop_address == req_address
            && snoop_data == '0)
        else flag_failure("clean read hit did not write the shared line");

    writeback_issue: assert property (@(posedge clock) disable iff (reset)
        lookup && hit && status_bits[0] && (req_msg inside {R_REQ, FLUSH_S})
        |=> invalidate && !write
            && ((req_msg == R_REQ && snoop_msg == C_WB)
                || (req_msg == FLUSH_S && snoop_msg == C_FLUSH))
            && snoop_address == {req_address[31:2], 2'b00} && snoop_data == $past(data_in)
        ##1 !invalidate)
        else flag_failure("dirty hit did not send the line back");

    writeback_done: assert property (@(posedge clock) disable iff (reset)
        state == WAIT_FOR_RESP && (snoop_msg inside {C_WB, C_FLUSH}) && intf_msg == MEM_RESP
        |=> snoop_msg == EN_ACCESS && snoop_address == req_address && snoop_data == '0)
        else flag_failure("no EN_ACCESS after the memory response");

    invalidate_only: assert property (@(posedge clock) disable iff (reset)
        lookup && hit && ((req_msg inside {RFO_BCAST, WS_BCAST})
                          || (req_msg == FLUSH_S && !status_bits[0]))
        |=> invalidate && !write && snoop_msg == EN_ACCESS
            && snoop_address == req_address && snoop_data == '0
        ##1 !invalidate)
        else flag_failure("hit was not invalidated with a single pulse");

    miss_access: assert property (@(posedge clock) disable iff (reset)
        lookup && !hit
        |=> !invalidate && !write && snoop_msg == EN_ACCESS && snoop_address == req_address
            && snoop_data == '0
        ##1 !invalidate && !write)
        else flag_failure("miss did not give a plain EN_ACCESS");

    release_done: assert property (@(posedge clock) disable iff (reset)
        state == WAIT_FOR_RESP && snoop_msg == EN_ACCESS && req_ready
        |=> snoop_msg == NO_REQ && snoop_address == '0 && snoop_data == '0)
        else flag_failure("snoop response not cleared after req_ready");

endmodule

bind snooper snooper_asserts asserts_i (.*, .state(controller_i.state));

//--- snooper_tb.sv
`timescale 1ns/10ps

module snooper_tb import snooper_pkg::*; ();

    localparam int clock_period        = 10;
    localparam int scenario_count      = 30;
    localparam int cycles_per_scenario = 20;

    logic     clock       = 1'b0;
    logic     reset       = 1'b1;
    line_t    data_in     = '0;
    way_t     matched_way = '0;
    status_t  status_bits = '0;
    logic     hit         = 1'b0;
    bus_msg_t intf_msg    = NO_REQ;
    bus_msg_t bus_msg     = NO_REQ;
    addr_t    bus_address = '0;
    logic     req_ready   = 1'b0;
    logic     bus_master  = 1'b0;

    logic     read, write, invalidate;
    index_t   index;
    tag_t     tag;
    meta_t    meta_data;
    line_t    data_out, snoop_data;
    way_t     way_select;
    bus_msg_t snoop_msg;
    addr_t    snoop_address;

    // contents of the line the current snoop looks up
    logic     line_hit   = 1'b0;
    logic     line_dirty = 1'b0;
    way_t     line_way   = '0;
    line_t    line_data  = '0;

    bus_msg_t snoop_kinds [4] = '{R_REQ, RFO_BCAST, WS_BCAST, FLUSH_S};
    int       errors;

    snooper snooper_i (.*);

    always #(clock_period / 2) clock = ~clock;

    // cache model, answers while read is high
    always @(posedge clock) begin
        if (read) begin
            hit         <= line_hit;
            status_bits <= {line_hit, line_dirty};  // valid, dirty
            matched_way <= line_way;
            data_in     <= line_data;
        end else begin
            hit         <= 1'b0;
            status_bits <= '0;
            matched_way <= '0;
            data_in     <= '0;
        end
    end

    // bus side answers a random 1 to 4 cycles later, for one cycle
    task automatic respond_later(input logic memory_response);
        int delay;
        delay = $urandom_range(4, 1);
        repeat (delay) @(posedge clock);
        if (memory_response) begin
            intf_msg <= MEM_RESP;
        end else begin
            req_ready <= 1'b1;
        end
        @(posedge clock);
        intf_msg  <= NO_REQ;
        req_ready <= 1'b0;
    endtask

    task automatic snoop_line(input bus_msg_t msg, input logic cached, input logic dirty);
        @(posedge clock);
        line_hit    <= cached;
        line_dirty  <= dirty;
        line_way    <= way_t'($urandom);
        line_data   <= {$urandom, $urandom, $urandom, $urandom};
        bus_msg     <= msg;
        bus_address <= $urandom;
        @(posedge clock);
        bus_msg <= NO_REQ;   // one cycle on the bus
        while (snoop_msg == NO_REQ) @(posedge clock);
        if (snoop_msg == C_WB || snoop_msg == C_FLUSH) begin
            respond_later(1'b1);
            while (snoop_msg != EN_ACCESS) @(posedge clock);
        end
        respond_later(1'b0);
        while (snoop_msg != NO_REQ) @(posedge clock);
    endtask

    // own request, or one during a bus completion
    task automatic ignored_request(input bus_msg_t msg, input logic own, input logic completing);
        @(posedge clock);
        bus_msg     <= msg;
        bus_address <= $urandom;
        bus_master  <= own;
        req_ready   <= completing;
        @(posedge clock);
        bus_msg    <= NO_REQ;
        bus_master <= 1'b0;
        req_ready  <= 1'b0;
        repeat (4) @(posedge clock);
    endtask

    initial begin
        void'($urandom(32'hb86f));
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);
        ignored_request(R_REQ, 1'b1, 1'b0);
        ignored_request(RFO_BCAST, 1'b0, 1'b1);
        ignored_request(EN_ACCESS, 1'b0, 1'b0);
        for (int pass = 0; pass < 2; pass++) begin
            foreach (snoop_kinds[k]) begin
                snoop_line(snoop_kinds[k], 1'b0, 1'b0);  // miss
                snoop_line(snoop_kinds[k], 1'b1, 1'b0);  // clean hit
                snoop_line(snoop_kinds[k], 1'b1, 1'b1);  // dirty hit
            end
        end
        ignored_request(FLUSH_S, 1'b1, 1'b0);
        ignored_request(WS_BCAST, 1'b0, 1'b1);
        ignored_request(MEM_RESP, 1'b0, 1'b0);
        repeat (4) @(posedge clock);  // let the last checks complete
        errors = snooper_i.asserts_i.error_count;
        $display("Summary: %0d assertion errors", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(scenario_count * cycles_per_scenario * clock_period);
        $display("Timeout: the run did not finish within %0d cycles",
                 scenario_count * cycles_per_scenario);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
snooper_pkg.sv
snoop_req_if.sv
snoop_request_capture.sv
snoop_line_controller.sv
snooper.sv
snooper_asserts.sv
snooper_tb.sv
